// File: verilog/predecode_pkg.sv
`default_nettype none

package predecode_pkg;

        // Instruction, address and status words.
        typedef logic [31:0] word_t;
        typedef logic [31:0] pc_t;
        typedef logic [31:0] cpsr_t;

        // Two-bit saturating branch state.
        typedef logic [1:0] taken_t;

        // Register list of a block transfer.
        typedef logic [15:0] regmask_t;

        // Predictor states.
        localparam taken_t TAKEN_SNT = 2'd0;
        localparam taken_t TAKEN_WNT = 2'd1;
        localparam taken_t TAKEN_WT  = 2'd2;
        localparam taken_t TAKEN_ST  = 2'd3;

        // CPSR flag positions.
        localparam int CPSR_T = 5;
        localparam int CPSR_F = 6;
        localparam int CPSR_I = 7;

        localparam logic [3:0] COND_AL = 4'b1110;

        // MOV R0,R0.
        localparam word_t ARM_NOP = 32'hE1A0_0000;

        // Permanently undefined ARM encoding.
        localparam word_t THUMB_UND_WORD = 32'hE7F0_00F0;

        typedef enum logic {
                LDM_IDLE,
                LDM_SPLIT
        } ldm_state_t;

endpackage

`default_nettype wire

// File: verilog/predecode_coproc.sv
`timescale 1ns/10ps
`default_nettype none

module predecode_coproc (
        input  wire logic                   i_clk,
        input  wire logic                   i_reset,
        input  wire logic                   i_clear,
        input  wire predecode_pkg::word_t   i_instruction,
        input  wire logic                   i_instruction_valid,
        input  wire predecode_pkg::cpsr_t   i_cpsr,
        input  wire logic                   i_copro_done,
        output predecode_pkg::word_t        o_instruction,
        output logic                        o_instruction_valid,
        output logic                        o_stall,
        output logic                        o_copro_dav,
        output predecode_pkg::word_t        o_copro_word
);

        logic                 is_copro;
        logic                 wait_q;
        predecode_pkg::word_t word_q;

        // CDP, MRC, MCR and the LDC/STC group, ARM state only.
        always_comb
        begin
                is_copro = i_instruction_valid && !i_cpsr[predecode_pkg::CPSR_T] &&
                           ((i_instruction[27:24] == 4'b1110) ||
                            (i_instruction[27:25] == 3'b110));
        end

        // Fetch holds the word on the inputs while we wait.
        assign o_instruction       = i_instruction;
        assign o_instruction_valid = i_instruction_valid && !is_copro && !wait_q;
        assign o_stall             = wait_q ? !i_copro_done : is_copro;
        assign o_copro_dav         = wait_q;
        assign o_copro_word        = word_q;

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                        wait_q <= 1'b0;
                else if (wait_q)
                        wait_q <= !i_copro_done;
                else
                        wait_q <= is_copro;
        end

        // Word presented to the coprocessor.
        always_ff @(posedge i_clk)
        begin
                if (!wait_q && is_copro)
                        word_q <= i_instruction;
        end

endmodule

`default_nettype wire

// File: verilog/predecode_thumb.sv
`timescale 1ns/10ps
`default_nettype none

module predecode_thumb (
        input  wire predecode_pkg::word_t   i_instruction,
        input  wire logic                   i_instruction_valid,
        input  wire predecode_pkg::cpsr_t   i_cpsr,
        output predecode_pkg::word_t        o_instruction,
        output logic                        o_instruction_valid,
        output logic                        o_half_offset,
        output logic                        o_und
);

        logic [15:0] half;
        logic [10:0] imm11;
        logic [2:0]  rd;
        logic [7:0]  imm8;

        // Thumb halfword sits in the low half of the fetched word.
        assign half  = i_instruction[15:0];
        assign imm11 = half[10:0];
        assign rd    = half[10:8];
        assign imm8  = half[7:0];

        always_comb
        begin
                o_instruction       = i_instruction;
                o_instruction_valid = i_instruction_valid;
                o_half_offset       = 1'b0;
                o_und               = 1'b0;

                if (i_cpsr[predecode_pkg::CPSR_T])
                begin
                        case (half[15:11])
                        5'b11100:
                        begin
                                // Unconditional B, offset counted in halfwords.
                                o_instruction = {predecode_pkg::COND_AL, 4'b1010,
                                                 {13{imm11[10]}}, imm11};
                                o_half_offset = 1'b1;
                        end
                        5'b00100:
                        begin
                                // MOVS Rd, #imm8.
                                o_instruction = {predecode_pkg::COND_AL, 8'h3B, 4'h0,
                                                 1'b0, rd, 4'h0, imm8};
                        end
                        default:
                        begin
                                o_instruction = predecode_pkg::THUMB_UND_WORD;
                                o_und         = i_instruction_valid;
                        end
                        endcase
                end
        end

endmodule

`default_nettype wire

// File: verilog/predecode_ldm_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module predecode_ldm_fsm (
        input  wire logic                   i_clk,
        input  wire logic                   i_reset,
        input  wire logic                   i_clear,
        input  wire logic                   i_hold,
        input  wire predecode_pkg::word_t   i_instruction,
        input  wire logic                   i_instruction_valid,
        input  wire logic                   i_irq,
        input  wire logic                   i_fiq,
        output predecode_pkg::word_t        o_instruction,
        output logic                        o_instruction_valid,
        output logic                        o_irq,
        output logic                        o_fiq,
        output logic                        o_stall
);

        predecode_pkg::ldm_state_t state_q;
        predecode_pkg::regmask_t   mask_q;
        logic [3:0]                index_q;

        logic                      splitting;
        predecode_pkg::regmask_t   work_mask;
        predecode_pkg::regmask_t   rest_mask;
        logic [3:0]                cur_reg;
        logic [3:0]                cur_index;
        predecode_pkg::word_t      micro_op;

        always_comb
        begin
                splitting = (state_q == predecode_pkg::LDM_SPLIT) ||
                            (i_instruction_valid && (i_instruction[27:25] == 3'b100));
                work_mask = (state_q == predecode_pkg::LDM_SPLIT) ? mask_q :
                                                                    i_instruction[15:0];
                cur_index = (state_q == predecode_pkg::LDM_SPLIT) ? index_q : 4'd0;

                // Lowest listed register goes first.
                cur_reg = 4'd0;
                for (int i = 15; i >= 0; i--)
                begin
                        if (work_mask[i])
                                cur_reg = 4'(i);
                end
                rest_mask = work_mask & (work_mask - 16'd1);

                // LDR/STR Rd, [Rn, #4*index], pre-indexed, no writeback.
                micro_op = {i_instruction[31:28], 2'b01, 1'b0, 1'b1, 1'b1, 1'b0, 1'b0,
                            i_instruction[20], i_instruction[19:16], cur_reg,
                            6'd0, cur_index, 2'b00};
        end

        always_comb
        begin
                if (splitting && (work_mask == '0))
                        o_instruction = predecode_pkg::THUMB_UND_WORD;
                else if (splitting)
                        o_instruction = micro_op;
                else
                        o_instruction = i_instruction;

                o_instruction_valid = (state_q == predecode_pkg::LDM_SPLIT) ||
                                      i_instruction_valid;
                o_stall = splitting && (rest_mask != '0);

                // Interrupts only on the first op.
                o_irq = i_irq && o_instruction_valid && (state_q == predecode_pkg::LDM_IDLE);
                o_fiq = i_fiq && o_instruction_valid && (state_q == predecode_pkg::LDM_IDLE);
        end

        always_ff @(posedge i_clk)
        begin
                if (i_reset || i_clear)
                        state_q <= predecode_pkg::LDM_IDLE;
                else if (!i_hold)
                begin
                        if (splitting && (rest_mask != '0))
                                state_q <= predecode_pkg::LDM_SPLIT;
                        else
                                state_q <= predecode_pkg::LDM_IDLE;
                end
        end

        // Remaining list and transfer index.
        always_ff @(posedge i_clk)
        begin
                if (!i_hold)
                begin
                        mask_q  <= rest_mask;
                        index_q <= cur_index + 4'd1;
                end
        end

endmodule

`default_nettype wire

// File: verilog/predecode_main.sv
`timescale 1ns/10ps
`default_nettype none

module predecode_main (
        input  wire logic                   i_clk,
        input  wire logic                   i_reset,
        input  wire predecode_pkg::taken_t  i_taken,
        input  wire logic                   i_clear_from_writeback,
        input  wire logic                   i_data_stall,
        input  wire logic                   i_clear_from_alu,
        input  wire logic                   i_stall_from_issue,
        input  wire logic                   i_irq,
        input  wire logic                   i_fiq,
        input  wire logic                   i_copro_done,
        input  wire predecode_pkg::pc_t     i_pc,
        input  wire predecode_pkg::cpsr_t   i_cpsr,
        input  wire predecode_pkg::word_t   i_instruction,
        input  wire logic                   i_instruction_valid,
        output predecode_pkg::word_t        o_instruction,
        output logic                        o_instruction_valid,
        output logic                        o_irq,
        output logic                        o_fiq,
        output logic                        o_und,
        output predecode_pkg::pc_t          o_pc,
        output predecode_pkg::taken_t       o_taken,
        output logic                        o_stall_from_decode,
        output logic                        o_copro_dav,
        output predecode_pkg::word_t        o_copro_word,
        output logic                        o_clear_from_decode,
        output predecode_pkg::pc_t          o_pc_from_decode
);

        logic                  irq_masked;
        logic                  fiq_masked;
        logic                  clear_any;
        logic                  hold_any;
        predecode_pkg::word_t  cp_instruction;
        logic                  cp_valid;
        logic                  cp_stall;
        predecode_pkg::word_t  th_instruction;
        logic                  th_valid;
        logic                  th_half_offset;
        logic                  th_und;
        predecode_pkg::word_t  ldm_instruction;
        logic                  ldm_valid;
        logic                  ldm_irq;
        logic                  ldm_fiq;
        logic                  ldm_stall;
        logic                  is_branch;
        logic                  is_al;
        predecode_pkg::pc_t    offset;
        predecode_pkg::pc_t    target;
        predecode_pkg::taken_t taken_nxt;

        assign irq_masked = i_irq && !i_cpsr[predecode_pkg::CPSR_I];
        assign fiq_masked = i_fiq && !i_cpsr[predecode_pkg::CPSR_F];

        // Writeback clear, then data stall, then ALU clear, then issue stall.
        assign clear_any = i_clear_from_writeback || (!i_data_stall && i_clear_from_alu);
        assign hold_any  = i_data_stall || i_stall_from_issue;

        assign o_stall_from_decode = cp_stall || ldm_stall;

        predecode_coproc u_coproc (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_clear             (clear_any),
                .i_instruction       (i_instruction),
                .i_instruction_valid (i_instruction_valid),
                .i_cpsr              (i_cpsr),
                .i_copro_done        (i_copro_done),
                .o_instruction       (cp_instruction),
                .o_instruction_valid (cp_valid),
                .o_stall             (cp_stall),
                .o_copro_dav         (o_copro_dav),
                .o_copro_word        (o_copro_word)
        );

        predecode_thumb u_thumb (
                .i_instruction       (cp_instruction),
                .i_instruction_valid (cp_valid),
                .i_cpsr              (i_cpsr),
                .o_instruction       (th_instruction),
                .o_instruction_valid (th_valid),
                .o_half_offset       (th_half_offset),
                .o_und               (th_und)
        );

        // Static prediction on B.
        always_comb
        begin
                is_branch = th_valid && (th_instruction[27:25] == 3'b101);
                is_al     = (th_instruction[31:28] == predecode_pkg::COND_AL);
                offset    = {{8{th_instruction[23]}}, th_instruction[23:0]};
                target    = i_pc + (i_cpsr[predecode_pkg::CPSR_T] ? 32'd4 : 32'd8);
                if (th_half_offset)
                        target = target + (offset << 1);
                else
                        target = target + (offset << 2);

                taken_nxt = (is_branch && is_al) ? predecode_pkg::TAKEN_ST : i_taken;

                o_clear_from_decode = is_branch && (i_taken[1] || is_al) &&
                                      !i_clear_from_writeback && !i_data_stall &&
                                      !i_clear_from_alu && !i_stall_from_issue;
                o_pc_from_decode    = o_clear_from_decode ? target : '0;
        end

        predecode_ldm_fsm u_ldm_fsm (
                .i_clk               (i_clk),
                .i_reset             (i_reset),
                .i_clear             (clear_any),
                .i_hold              (hold_any),
                .i_instruction       (th_instruction),
                .i_instruction_valid (th_valid),
                .i_irq               (irq_masked),
                .i_fiq               (fiq_masked),
                .o_instruction       (ldm_instruction),
                .o_instruction_valid (ldm_valid),
                .o_irq               (ldm_irq),
                .o_fiq               (ldm_fiq),
                .o_stall             (ldm_stall)
        );

        // Output register.
        always_ff @(posedge i_clk)
        begin
                if (i_reset || clear_any)
                begin
                        o_instruction       <= predecode_pkg::ARM_NOP;
                        o_instruction_valid <= 1'b0;
                        o_irq               <= 1'b0;
                        o_fiq               <= 1'b0;
                        o_und               <= 1'b0;
                        o_taken             <= predecode_pkg::TAKEN_SNT;
                end
                else if (!hold_any)
                begin
                        o_instruction       <= ldm_instruction;
                        o_instruction_valid <= ldm_valid;
                        o_irq               <= ldm_irq;
                        o_fiq               <= ldm_fiq;
                        o_und               <= th_und;
                        o_taken             <= taken_nxt;
                end
        end

        // PC follows each micro-op.
        always_ff @(posedge i_clk)
        begin
                if (!clear_any && !hold_any)
                        o_pc <= i_pc;
        end

endmodule

`default_nettype wire

// File: verif/predecode_tb.sv
`timescale 1ns/10ps
`default_nettype none

module predecode_tb;

        logic i_clk, i_reset, i_clear_from_writeback, i_data_stall, i_clear_from_alu;
        logic i_stall_from_issue, i_irq, i_fiq, i_copro_done, i_instruction_valid;
        predecode_pkg::taken_t i_taken, o_taken;
        predecode_pkg::pc_t    i_pc, o_pc, o_pc_from_decode, next_pc, exp_tgt;
        predecode_pkg::cpsr_t  i_cpsr;
        predecode_pkg::word_t  i_instruction, o_instruction, o_copro_word, last_word;
        logic o_instruction_valid, o_irq, o_fiq, o_und, o_stall_from_decode, o_copro_dav;
        logic o_clear_from_decode, was_hold, was_clear, last_valid, exp_pred, exp_und;
        predecode_pkg::taken_t exp_taken;
        predecode_pkg::word_t  exp_ops[16];
        predecode_pkg::word_t  q_word[$];
        predecode_pkg::pc_t    q_pc[$];
        predecode_pkg::taken_t q_taken[$];
        logic q_irq[$], q_fiq[$], q_und[$];
        integer seed = 32'h83db73d0;
        int value_errors = 0;
        int other_errors = 0;

        predecode_main dut (.*);

        initial
        begin
                i_clk = 1'b0;
                forever #20 i_clk = ~i_clk;
        end

        task automatic check_word(string name, predecode_pkg::word_t got,
                                  predecode_pkg::word_t exp);
                if (got !== exp)
                begin
                        value_errors++;
                        $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_pc(string name, predecode_pkg::pc_t got, predecode_pkg::pc_t exp);
                if (got !== exp)
                begin
                        value_errors++;
                        $display("Error at %0t: %s is %h, expected %h", $time, name, got, exp);
                end
        endtask

        task automatic check_taken(string name, predecode_pkg::taken_t got,
                                   predecode_pkg::taken_t exp);
                if (got !== exp)
                begin
                        value_errors++;
                        $display("Error at %0t: %s is %0d, expected %0d", $time, name, got, exp);
                end
        endtask

        task automatic check_flag(string name, logic got, logic exp);
                if (got !== exp)
                begin
                        value_errors++;
                        $display("Error at %0t: %s is %b, expected %b", $time, name, got, exp);
                end
        endtask

        task automatic report_timeout(string what);
                $display("Timeout at %0t: %s never came", $time, what);
                $display("value errors %0d, other errors %0d, timeouts 1",
                         value_errors, other_errors);
                $display("SOME TESTS FAILED");
                $finish;
        endtask

        // Expected micro-ops into exp_ops, prediction into exp_pred and exp_tgt.
        function automatic int expected_ops(predecode_pkg::word_t w, predecode_pkg::pc_t pc,
                                            predecode_pkg::cpsr_t c, predecode_pkg::taken_t tk);
                predecode_pkg::word_t arm;
                predecode_pkg::pc_t   off;
                logic                 half;
                int                   n;
                arm = w;
                half = 1'b0;
                exp_und = 1'b0;
                n = 0;
                if (c[5])
                begin
                        if (w[15:11] == 5'b11100)
                        begin
                                arm = {4'hE, 4'hA, {13{w[10]}}, w[10:0]};
                                half = 1'b1;
                        end
                        else if (w[15:11] == 5'b00100)
                                arm = {4'hE, 3'b001, 4'b1101, 1'b1, 4'h0, 1'b0, w[10:8],
                                       4'h0, w[7:0]};
                        else
                        begin
                                arm = predecode_pkg::THUMB_UND_WORD;
                                exp_und = 1'b1;
                        end
                end
                exp_pred = (arm[27:25] == 3'b101) && (tk[1] || arm[31:28] == 4'hE);
                exp_taken = (arm[27:25] == 3'b101 && arm[31:28] == 4'hE) ?
                            predecode_pkg::TAKEN_ST : tk;
                off = {{8{arm[23]}}, arm[23:0]};
                exp_tgt = pc + (c[5] ? 32'd4 : 32'd8) + (half ? off << 1 : off << 2);
                if (arm[27:25] == 3'b100)
                begin
                        for (int i = 0; i < 16; i++)
                        begin
                                if (arm[i])
                                begin
                                        exp_ops[n] = {arm[31:28], 3'b010, 2'b11, 2'b00, arm[20],
                                                      arm[19:16], 4'(i), 12'(4 * n)};
                                        n++;
                                end
                        end
                        if (n == 0)
                        begin
                                exp_ops[0] = predecode_pkg::THUMB_UND_WORD;
                                n = 1;
                        end
                end
                else
                begin
                        exp_ops[0] = arm;
                        n = 1;
                end
                return n;
        endfunction

        task automatic send(predecode_pkg::word_t w, predecode_pkg::cpsr_t c, logic irq, logic fiq,
                            predecode_pkg::taken_t tk, logic stress);
                int  n;
                int  t;
                logic hold;
                @(negedge i_clk);
                {i_instruction, i_cpsr, i_irq, i_fiq, i_taken} = {w, c, irq, fiq, tk};
                i_pc = next_pc;
                i_instruction_valid = 1'b1;
                n = expected_ops(w, next_pc, c, tk);
                for (int k = 0; k < n; k++)
                begin
                        q_word.push_back(exp_ops[k]);
                        q_pc.push_back(next_pc);
                        q_taken.push_back(exp_taken);
                        q_irq.push_back(k == 0 && irq && !c[predecode_pkg::CPSR_I]);
                        q_fiq.push_back(k == 0 && fiq && !c[predecode_pkg::CPSR_F]);
                        q_und.push_back(exp_und);
                end
                t = 0;
                forever
                begin
                        if (stress)
                        begin
                                i_data_stall = ($random(seed) % 4 == 0);
                                i_stall_from_issue = ($random(seed) % 4 == 0);
                                // Under a data stall the ALU clear must lose.
                                i_clear_from_alu = i_data_stall && $random(seed) % 2;
                        end
                        hold = i_data_stall || i_stall_from_issue || i_clear_from_alu;
                        #5;
                        if (t == 0)
                        begin
                                check_flag("o_clear_from_decode", o_clear_from_decode,
                                           exp_pred && !hold);
                                if (exp_pred && !hold)
                                        check_pc("o_pc_from_decode", o_pc_from_decode, exp_tgt);
                        end
                        if (!o_stall_from_decode && !hold)
                                break;
                        @(negedge i_clk);
                        t++;
                        if (t > 60)
                                report_timeout("acceptance of the instruction");
                end
                if (!stress && t != n - 1)
                begin
                        other_errors++;
                        $display("Fetch stall lasted %0d cycles for %0d micro-ops", t, n);
                end
                @(negedge i_clk);
                {i_instruction_valid, i_data_stall, i_stall_from_issue, i_clear_from_alu} = '0;
                next_pc = next_pc + 32'd4;
        endtask

        task automatic send_copro(predecode_pkg::word_t w, int delay);
                int t;
                @(negedge i_clk);
                {i_instruction, i_cpsr, i_irq, i_fiq} = {w, 32'h0, 2'b00};
                i_instruction_valid = 1'b1;
                #5 check_flag("o_stall_from_decode", o_stall_from_decode, 1'b1);
                t = 0;
                while (!o_copro_dav)
                begin
                        @(negedge i_clk);
                        t++;
                        if (t > 10)
                                report_timeout("o_copro_dav");
                end
                check_word("o_copro_word", o_copro_word, w);
                repeat (delay)
                begin
                        check_flag("o_stall_from_decode", o_stall_from_decode, 1'b1);
                        @(negedge i_clk);
                end
                i_copro_done = 1'b1;
                @(negedge i_clk);
                {i_copro_done, i_instruction_valid} = 2'b00;
                check_flag("o_copro_dav", o_copro_dav, 1'b0);
        endtask

        // A clear in the middle of a split throws the rest away.
        task automatic abandon_ldm(predecode_pkg::word_t w, logic from_wb);
                int n;
                @(negedge i_clk);
                {i_instruction, i_cpsr, i_irq, i_fiq, i_instruction_valid} = {w, 32'h0, 3'b001};
                n = expected_ops(w, next_pc, 32'h0, i_taken);
                i_pc = next_pc;
                for (int k = 0; k < n; k++)
                begin
                        q_word.push_back(exp_ops[k]);
                        q_pc.push_back(next_pc);
                        q_taken.push_back(exp_taken);
                        q_irq.push_back(1'b0);
                        q_fiq.push_back(1'b0);
                        q_und.push_back(1'b0);
                end
                @(negedge i_clk);
                i_instruction_valid = 1'b0;
                i_clear_from_writeback = from_wb;
                i_clear_from_alu = !from_wb;
                @(negedge i_clk);
                {i_clear_from_writeback, i_clear_from_alu} = 2'b00;
                next_pc = next_pc + 32'd4;
        endtask

        always @(posedge i_clk)
        begin
                was_hold <= i_data_stall || i_stall_from_issue;
                was_clear <= i_reset || i_clear_from_writeback ||
                             (i_clear_from_alu && !i_data_stall);
        end

        // Compares every newly loaded output against the expected queue.
        always @(negedge i_clk)
        begin
                if (was_clear)
                begin
                        check_word("o_instruction", o_instruction, predecode_pkg::ARM_NOP);
                        check_flag("o_instruction_valid", o_instruction_valid, 1'b0);
                        check_flag("o_irq", o_irq, 1'b0);
                        check_flag("o_fiq", o_fiq, 1'b0);
                        check_flag("o_und", o_und, 1'b0);
                        check_taken("o_taken", o_taken, predecode_pkg::TAKEN_SNT);
                        q_word.delete();
                        q_pc.delete();
                        q_taken.delete();
                        q_irq.delete();
                        q_fiq.delete();
                        q_und.delete();
                end
                else if (was_hold)
                begin
                        check_word("o_instruction", o_instruction, last_word);
                        check_flag("o_instruction_valid", o_instruction_valid, last_valid);
                end
                else if (o_instruction_valid)
                begin
                        if (q_word.size() == 0)
                        begin
                                other_errors++;
                                $display("A valid output appeared at %0t with nothing expected",
                                         $time);
                        end
                        else
                        begin
                                check_word("o_instruction", o_instruction, q_word.pop_front());
                                check_pc("o_pc", o_pc, q_pc.pop_front());
                                check_taken("o_taken", o_taken, q_taken.pop_front());
                                check_flag("o_irq", o_irq, q_irq.pop_front());
                                check_flag("o_fiq", o_fiq, q_fiq.pop_front());
                                check_flag("o_und", o_und, q_und.pop_front());
                        end
                end
                last_word = o_instruction;
                last_valid = o_instruction_valid;
        end

        initial
        begin
                predecode_pkg::word_t r;
                int t;
                {i_reset, i_clear_from_writeback, i_data_stall, i_clear_from_alu} = 4'b1000;
                {i_stall_from_issue, i_irq, i_fiq, i_copro_done, i_instruction_valid} = '0;
                {i_taken, i_pc, i_cpsr, i_instruction, next_pc} = '0;
                next_pc = 32'h0000_1000;
                repeat (3) @(posedge i_clk);
                @(negedge i_clk);
                i_reset = 1'b0;
                @(negedge i_clk);
                check_flag("o_instruction_valid", o_instruction_valid, 1'b0);
                check_flag("o_copro_dav", o_copro_dav, 1'b0);
                check_flag("o_stall_from_decode", o_stall_from_decode, 1'b0);
                check_flag("o_clear_from_decode", o_clear_from_decode, 1'b0);
                check_flag("o_irq", o_irq, 1'b0);
                check_flag("o_fiq", o_fiq, 1'b0);
                check_flag("o_und", o_und, 1'b0);

                repeat (20)
                begin
                        r = $random(seed);
                        send({r[31:28], 2'b00, r[25:0]}, 32'h0, 1'b0, 1'b0,
                             2'($random(seed)), 1'b0);
                end
                repeat (20)
                begin
                        r = $random(seed);
                        send({r[31:28], 4'b1010, r[23:0]}, 32'h0, 1'b0, 1'b0,
                             2'($random(seed)), 1'b0);
                end
                send(32'hE891_0000, 32'h0, 1'b0, 1'b0, 2'd0, 1'b0);
                repeat (12)
                begin
                        r = $random(seed);
                        send({r[31:28], 3'b100, 4'b0100, r[20:0]}, 32'h0, 1'b0, 1'b0, 2'd1, 1'b0);
                end
                repeat (24)
                begin
                        r = $random(seed);
                        if (r[31:30] == 2'd0)
                                r[15:11] = 5'b11100;
                        else if (r[31:30] == 2'd1)
                                r[15:11] = 5'b00100;
                        send(r, 32'h20, 1'b0, 1'b0, 2'($random(seed)), 1'b0);
                end
                repeat (4)
                begin
                        r = $random(seed);
                        send_copro({r[31:28], 4'b1110, r[23:0]}, $unsigned($random(seed)) % 6);
                        send(32'hE281_1001, 32'h0, 1'b0, 1'b0, 2'd0, 1'b0);
                end
                repeat (40)
                begin
                        r = $random(seed);
                        if (r[1:0] == 2'd0)
                                r[27:25] = 3'b101;
                        else if (r[1:0] == 2'd1)
                                r[27:21] = 7'b1000100;
                        else
                                r[27:26] = 2'b00;
                        send(r, {24'h0, r[7:6], 6'h0}, r[5], r[4], 2'(r[3:2]), 1'b1);
                end
                abandon_ldm(32'hE890_00F6, 1'b1);
                abandon_ldm(32'hE891_0E0E, 1'b0);
                send(32'hE3A0_0042, 32'h0, 1'b1, 1'b1, 2'd0, 1'b0);

                t = 0;
                while (q_word.size() != 0)
                begin
                        @(negedge i_clk);
                        t++;
                        if (t > 20)
                                report_timeout("the last expected output");
                end
                repeat (2) @(negedge i_clk);
                $display("value errors %0d, other errors %0d, timeouts 0",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0)
                        $display("ALL TESTS PASSED");
                else
                        $display("SOME TESTS FAILED");
                $finish;
        end

endmodule

`default_nettype wire

// File: predecode.f
verilog/predecode_pkg.sv
verilog/predecode_coproc.sv
verilog/predecode_thumb.sv
verilog/predecode_ldm_fsm.sv
verilog/predecode_main.sv
verif/predecode_tb.sv

// File: Bender.yml
package:
  name: predecode

sources:
  - verilog/predecode_pkg.sv
  - verilog/predecode_coproc.sv
  - verilog/predecode_thumb.sv
  - verilog/predecode_ldm_fsm.sv
  - verilog/predecode_main.sv
  - target: simulation
    files:
      - verif/predecode_tb.sv
